// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
TOP       := tb_rv_frontend
FILELIST  := tb.f
BUILD_DIR := obj_dir

SOURCES   := $(shell grep -v '^+' $(FILELIST)) verification/tb_vectors.svh
SIM_EXE   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_EXE)
	./$(SIM_EXE)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/compressed_expander.sv ====
`timescale 1ns/100ps
`default_nettype none

module compressed_expander
    import rv_frontend_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n,

    instr_stream_if.dst in,
    instr_stream_if.src out
);

logic [half_width-1:0] c;
logic [4:0]            rs1p;
logic [4:0]            rs2p;
logic [11:0]           imm6;
rv_instr_u             x;
logic                  bad;

function automatic rv_instr_u make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [6:0] op);
    rv_instr_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = op;
    return w;
endfunction

function automatic rv_instr_u make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
    rv_instr_u w;
    w.i.imm12  = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = op;
    return w;
endfunction

function automatic rv_instr_u make_s(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [6:0] op);
    rv_instr_u w;
    w.s.imm_hi = imm[11:5];
    w.s.rs2    = rs2;
    w.s.rs1    = rs1;
    w.s.funct3 = f3;
    w.s.imm_lo = imm[4:0];
    w.s.opcode = op;
    return w;
endfunction

assign c    = in.word[half_width-1:0];
assign rs1p = {2'b01, c[9:7]};          // x8..x15
assign rs2p = {2'b01, c[4:2]};
assign imm6 = {{6{c[12]}}, c[12], c[6:2]};

always_comb
begin
    x   = in.word;
    bad = in.compressed;                // Cleared by each supported form
    if (in.compressed)
    begin
        case (c[1:0])
            2'b00:
            begin
                if (c[15:13] == 3'b010)        // C.LW
                begin
                    x   = make_i({5'b0, c[5], c[12:10], c[6], 2'b00}, rs1p, 3'b010, rs2p,
                                 op_load);
                    bad = 1'b0;
                end
                else if (c[15:13] == 3'b110)   // C.SW
                begin
                    x   = make_s({5'b0, c[5], c[12:10], c[6], 2'b00}, rs2p, rs1p, 3'b010,
                                 op_store);
                    bad = 1'b0;
                end
            end
            2'b01:
            begin
                if (c[15:13] == 3'b000)        // C.ADDI
                begin
                    x   = make_i(imm6, c[11:7], 3'b000, c[11:7], op_imm);
                    bad = 1'b0;
                end
                else if (c[15:13] == 3'b010)   // C.LI
                begin
                    x   = make_i(imm6, 5'd0, 3'b000, c[11:7], op_imm);
                    bad = 1'b0;
                end
                else if (c[15:13] == 3'b011 && c[11:7] != 5'd2)   // C.LUI
                begin
                    x   = {{14{c[12]}}, c[12], c[6:2], c[11:7], op_lui};
                    bad = 1'b0;
                end
                else if (c[15:13] == 3'b100)
                begin
                    bad = 1'b0;
                    case (c[11:10])
                        2'b00: x = make_i({6'b000000, c[12], c[6:2]}, rs1p, 3'b101, rs1p,
                                          op_imm);                          // C.SRLI
                        2'b01: x = make_i({6'b010000, c[12], c[6:2]}, rs1p, 3'b101, rs1p,
                                          op_imm);                          // C.SRAI
                        2'b10: x = make_i(imm6, rs1p, 3'b111, rs1p, op_imm); // C.ANDI
                        default:
                        begin
                            case (c[6:5])
                                2'b00:   x = make_r(7'b0100000, rs2p, rs1p, 3'b000, rs1p,
                                                    op_reg);                // C.SUB
                                2'b01:   x = make_r(7'b0, rs2p, rs1p, 3'b100, rs1p, op_reg);
                                2'b10:   x = make_r(7'b0, rs2p, rs1p, 3'b110, rs1p, op_reg);
                                default: x = make_r(7'b0, rs2p, rs1p, 3'b111, rs1p, op_reg);
                            endcase
                            bad = c[12];                // RV64 only forms
                        end
                    endcase
                end
            end
            2'b10:
            begin
                if (c[15:13] == 3'b000)        // C.SLLI
                begin
                    x   = make_i({6'b0, c[12], c[6:2]}, c[11:7], 3'b001, c[11:7], op_imm);
                    bad = 1'b0;
                end
                else if (c[15:13] == 3'b100 && c[6:2] != 5'd0)
                begin
                    // C.ADD adds rd, C.MV adds x0
                    x   = make_r(7'b0, c[6:2], c[12] ? c[11:7] : 5'd0, 3'b000, c[11:7], op_reg);
                    bad = 1'b0;
                end
            end
            default: bad = 1'b1;
        endcase
        if (bad)
        begin
            x = in.word;                // Unsupported, forwarded as is
        end
    end
end

assign in.ready = !out.valid || out.ready;

always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        out.valid <= 1'b0;
    end
    else if (in.ready)
    begin
        out.valid <= in.valid;
    end
end

always_ff @(posedge clk)
begin
    if (in.valid && in.ready)
    begin
        out.word       <= x;
        out.pc         <= in.pc;
        out.compressed <= in.compressed;
        out.illegal    <= in.illegal || bad;
    end
end

endmodule

`default_nettype wire

// ==== design/fetch_apb_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_apb_master
    import rv_frontend_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,

    output logic            psel,
    output logic            penable,
    output addr_t           paddr,
    output logic            pwrite,
    input  wire [xlen-1:0]  prdata,
    input  wire             pready,

    input  wire             aligner_room,
    output logic            word_valid,
    output logic [xlen-1:0] word_data
);

addr_t fetch_addr;
logic  done;

assign done = psel && penable && pready;

// psel/penable double as the phase state
always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        psel    <= 1'b0;
        penable <= 1'b0;
    end
    else if (!psel)
    begin
        if (aligner_room)
        begin
            psel <= 1'b1;           // Setup phase
        end
    end
    else if (!penable)
    begin
        penable <= 1'b1;            // Access phase
    end
    else if (pready)
    begin
        penable <= 1'b0;
        psel    <= aligner_room;    // Back to back if buffer has room
    end
end

always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        fetch_addr <= reset_pc;
    end
    else if (done)
    begin
        fetch_addr <= fetch_addr + 32'd4;
    end
end

assign paddr  = fetch_addr;
assign pwrite = 1'b0;

// One cycle pulse on completion
assign word_valid = done;
assign word_data  = prdata;

endmodule

`default_nettype wire

// ==== design/instr_aligner.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_aligner
    import rv_frontend_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n,

    input  wire            word_valid,
    input  wire [xlen-1:0] word_data,
    output logic           aligner_room,

    instr_stream_if.src    out
);

logic [4*half_width-1:0] queue_q;     // Slot 0 in the low halfword
logic [4*half_width-1:0] queue_n;
logic [2:0]              count_q;
logic [2:0]              pop_cnt;
logic [2:0]              push_at;
logic [2:0]              fill;
addr_t                   pc_q;
logic                    head_c;
logic                    fire;

assign head_c = queue_q[1:0] != 2'b11;

assign out.valid      = head_c ? (count_q != 3'd0) : (count_q >= 3'd2);
assign out.pc         = pc_q;
assign out.compressed = head_c;
assign out.illegal    = 1'b0;
assign out.word       = head_c ? {{half_width{1'b0}}, queue_q[half_width-1:0]}
                               : queue_q[xlen-1:0];

assign fire    = out.valid && out.ready;
assign pop_cnt = !fire ? 3'd0 : (head_c ? 3'd1 : 3'd2);
assign push_at = count_q - pop_cnt;

// Counts the word landing this cycle, pops ignored
assign fill         = count_q + (word_valid ? 3'd2 : 3'd0);
assign aligner_room = fill <= 3'd2;

always_comb
begin
    case (pop_cnt)
        3'd1:    queue_n = {{half_width{1'b0}}, queue_q[4*half_width-1:half_width]};
        3'd2:    queue_n = {{xlen{1'b0}}, queue_q[4*half_width-1:xlen]};
        default: queue_n = queue_q;
    endcase

    if (word_valid)
    begin
        case (push_at)
            3'd0:    queue_n[xlen-1:0]        = word_data;
            3'd1:    queue_n[half_width+:xlen] = word_data;
            default: queue_n[xlen+:xlen]       = word_data;
        endcase
    end
end

always_ff @(posedge clk)
begin
    queue_q <= queue_n;
end

always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        count_q <= 3'd0;
        pc_q    <= reset_pc;
    end
    else
    begin
        count_q <= push_at + (word_valid ? 3'd2 : 3'd0);
        pc_q    <= pc_q + addr_t'({pop_cnt, 1'b0});     // 2 or 4 per instruction
    end
end

endmodule

`default_nettype wire

// ==== design/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decoder
    import rv_frontend_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,

    instr_stream_if.dst     in,

    output logic            out_valid,
    input  wire             out_ready,
    output addr_t           out_pc,
    output logic            out_compressed,
    output logic            out_illegal,
    output logic [6:0]      out_opcode,
    output logic [4:0]      out_rd,
    output logic [4:0]      out_rs1,
    output logic [4:0]      out_rs2,
    output logic [2:0]      out_funct3,
    output logic [6:0]      out_funct7,
    output logic [xlen-1:0] out_imm
);

logic [xlen-1:0] imm;

always_comb
begin
    case (in.word.r.opcode)
        op_load, op_imm: imm = {{20{in.word.i.imm12[11]}}, in.word.i.imm12};
        op_store:        imm = {{20{in.word.s.imm_hi[6]}}, in.word.s.imm_hi, in.word.s.imm_lo};
        op_lui:          imm = {in.word[31:12], 12'b0};
        op_reg:          imm = '0;
        default:         imm = '0;      // Unknown opcode
    endcase
end

assign in.ready = !out_valid || out_ready;

always_ff @(posedge clk or negedge arst_n)
begin
    if (!arst_n)
    begin
        out_valid <= 1'b0;
    end
    else if (in.ready)
    begin
        out_valid <= in.valid;
    end
end

always_ff @(posedge clk)
begin
    if (in.valid && in.ready)
    begin
        out_pc         <= in.pc;
        out_compressed <= in.compressed;
        out_illegal    <= in.illegal;
        out_opcode     <= in.word.r.opcode;
        out_rd         <= in.word.r.rd;
        out_rs1        <= in.word.r.rs1;
        out_rs2        <= in.word.r.rs2;
        out_funct3     <= in.word.r.funct3;
        out_funct7     <= in.word.r.funct7;
        out_imm        <= imm;
    end
end

endmodule

`default_nettype wire

// ==== design/instr_stream_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface instr_stream_if
    import rv_frontend_pkg::*;
();

    logic      valid;
    logic      ready;
    addr_t     pc;
    rv_instr_u word;
    logic      compressed;  // Came in as 16 bits
    logic      illegal;

    modport src (
        output valid, pc, word, compressed, illegal,
        input  ready
    );

    modport dst (
        input  valid, pc, word, compressed, illegal,
        output ready
    );

endinterface

`default_nettype wire

// ==== design/rv_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_frontend
    import rv_frontend_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,

    // APB instruction memory
    output logic            psel,
    output logic            penable,
    output addr_t           paddr,
    output logic            pwrite,
    input  wire [xlen-1:0]  prdata,
    input  wire             pready,

    // Decoded instruction stream
    output logic            out_valid,
    input  wire             out_ready,
    output addr_t           out_pc,
    output logic            out_compressed,
    output logic            out_illegal,
    output logic [6:0]      out_opcode,
    output logic [4:0]      out_rd,
    output logic [4:0]      out_rs1,
    output logic [4:0]      out_rs2,
    output logic [2:0]      out_funct3,
    output logic [6:0]      out_funct7,
    output logic [xlen-1:0] out_imm
);

logic            word_valid;
logic [xlen-1:0] word_data;
logic            aligner_room;

instr_stream_if a2e ();
instr_stream_if e2d ();

fetch_apb_master u_fetch (
    .clk          (clk),
    .arst_n       (arst_n),
    .psel         (psel),
    .penable      (penable),
    .paddr        (paddr),
    .pwrite       (pwrite),
    .prdata       (prdata),
    .pready       (pready),
    .aligner_room (aligner_room),
    .word_valid   (word_valid),
    .word_data    (word_data)
);

instr_aligner u_aligner (
    .clk          (clk),
    .arst_n       (arst_n),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .aligner_room (aligner_room),
    .out          (a2e.src)
);

compressed_expander u_expander (
    .clk    (clk),
    .arst_n (arst_n),
    .in     (a2e.dst),
    .out    (e2d.src)
);

instr_decoder u_decoder (
    .clk            (clk),
    .arst_n         (arst_n),
    .in             (e2d.dst),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_pc         (out_pc),
    .out_compressed (out_compressed),
    .out_illegal    (out_illegal),
    .out_opcode     (out_opcode),
    .out_rd         (out_rd),
    .out_rs1        (out_rs1),
    .out_rs2        (out_rs2),
    .out_funct3     (out_funct3),
    .out_funct7     (out_funct7),
    .out_imm        (out_imm)
);

endmodule

`default_nettype wire

// ==== design/rv_frontend_pkg.sv ====
`default_nettype none

package rv_frontend_pkg;

    localparam int xlen       = 32;
    localparam int half_width = 16;

    typedef logic [xlen-1:0] addr_t;

    localparam addr_t reset_pc = '0;

    // Major opcodes out of the expander
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_lui   = 7'b0110111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;     // imm[11:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;     // imm[4:0]
            logic [6:0] opcode;
        } s;
    } rv_instr_u;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+verification
design/rv_frontend_pkg.sv
design/instr_stream_if.sv
design/fetch_apb_master.sv
design/instr_aligner.sv
design/compressed_expander.sv
design/instr_decoder.sv
design/rv_frontend.sv
verification/tb_rv_frontend.sv

// ==== verification/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int num_hw    = 24;
localparam int num_instr = 21;

typedef struct packed {
    addr_t           pc;
    logic            compressed;
    logic            illegal;
    rv_instr_u       word;          // Expanded form
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] imm;
} expect_t;

// Program image, halfword 0 at address 0
logic [half_width-1:0] prog_hw [0:num_hw-1] = '{
    16'h0293, 16'hFFD3, 16'h556D, 16'h03B3, 16'h0094, 16'h5544, 16'hC62C, 16'h17C1,
    16'h730D, 16'h800D, 16'h8495, 16'h997D, 16'h8D91, 16'h8EB9, 16'h8F5D, 16'h8C65,
    16'h0A1E, 16'h8ADA, 16'h9BE2, 16'h4082, 16'h2C23, 16'hFE51, 16'h6495, 16'h467D
};

// pc, compressed, illegal, expanded word, rd, rs1, rs2, immediate
expect_t exp_table [0:num_instr-1] = '{
    {32'h00, 1'b0, 1'b0, 32'hFFD30293, 5'd5,  5'd6,  5'd29, 32'hFFFFFFFD},  // addi x5,x6,-3
    {32'h04, 1'b1, 1'b0, 32'hFFB00513, 5'd10, 5'd0,  5'd27, 32'hFFFFFFFB},  // C.LI
    {32'h06, 1'b0, 1'b0, 32'h009403B3, 5'd7,  5'd8,  5'd9,  32'h00000000},  // add, unaligned
    {32'h0A, 1'b1, 1'b0, 32'h02C52483, 5'd9,  5'd10, 5'd12, 32'h0000002C},  // C.LW
    {32'h0C, 1'b1, 1'b0, 32'h04B62423, 5'd8,  5'd12, 5'd11, 32'h00000048},  // C.SW
    {32'h0E, 1'b1, 1'b0, 32'hFF078793, 5'd15, 5'd15, 5'd16, 32'hFFFFFFF0},  // C.ADDI
    {32'h10, 1'b1, 1'b0, 32'hFFFE3337, 5'd6,  5'd28, 5'd31, 32'hFFFE3000},  // C.LUI
    {32'h12, 1'b1, 1'b0, 32'h00345413, 5'd8,  5'd8,  5'd3,  32'h00000003},  // C.SRLI
    {32'h14, 1'b1, 1'b0, 32'h4054D493, 5'd9,  5'd9,  5'd5,  32'h00000405},  // C.SRAI
    {32'h16, 1'b1, 1'b0, 32'hFFF57513, 5'd10, 5'd10, 5'd31, 32'hFFFFFFFF},  // C.ANDI
    {32'h18, 1'b1, 1'b0, 32'h40C585B3, 5'd11, 5'd11, 5'd12, 32'h00000000},  // C.SUB
    {32'h1A, 1'b1, 1'b0, 32'h00E6C6B3, 5'd13, 5'd13, 5'd14, 32'h00000000},  // C.XOR
    {32'h1C, 1'b1, 1'b0, 32'h00F76733, 5'd14, 5'd14, 5'd15, 32'h00000000},  // C.OR
    {32'h1E, 1'b1, 1'b0, 32'h00947433, 5'd8,  5'd8,  5'd9,  32'h00000000},  // C.AND
    {32'h20, 1'b1, 1'b0, 32'h007A1A13, 5'd20, 5'd20, 5'd7,  32'h00000007},  // C.SLLI
    {32'h22, 1'b1, 1'b0, 32'h01600AB3, 5'd21, 5'd0,  5'd22, 32'h00000000},  // C.MV
    {32'h24, 1'b1, 1'b0, 32'h018B8BB3, 5'd23, 5'd23, 5'd24, 32'h00000000},  // C.ADD
    {32'h26, 1'b1, 1'b1, 32'h00004082, 5'd1,  5'd0,  5'd0,  32'h00000000},  // C.LWSP
    {32'h28, 1'b0, 1'b0, 32'hFE512C23, 5'd24, 5'd2,  5'd5,  32'hFFFFFFF8},  // sw x5,-8(x2)
    {32'h2C, 1'b1, 1'b0, 32'h000054B7, 5'd9,  5'd0,  5'd0,  32'h00005000},  // C.LUI
    {32'h2E, 1'b1, 1'b0, 32'h01F00613, 5'd12, 5'd0,  5'd31, 32'h0000001F}   // C.LI
};

`endif

// ==== verification/tb_rv_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_frontend
    import rv_frontend_pkg::*;
();

`include "tb_vectors.svh"

localparam int timeout_cycles = num_instr * 40;

logic            clk;
logic            arst_n;
logic            psel;
logic            penable;
addr_t           paddr;
logic            pwrite;
logic [xlen-1:0] prdata;
logic            pready;
logic            out_valid;
logic            out_ready;
addr_t           out_pc;
logic            out_compressed;
logic            out_illegal;
logic [6:0]      out_opcode;
logic [4:0]      out_rd;
logic [4:0]      out_rs1;
logic [4:0]      out_rs2;
logic [2:0]      out_funct3;
logic [6:0]      out_funct7;
logic [xlen-1:0] out_imm;

logic [31:0]     lcg_state = 32'hb8cf92d8;
logic [31:0]     rnd;
logic [1:0]      wait_left;
int              cycle_count = 0;
int              i;
rv_instr_u       got;

rv_frontend UUT (.*);

initial clk = 1'b0;
always #20 clk = ~clk;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Past the program the memory returns the inverted address as data
function automatic logic [xlen-1:0] fetch_word(input addr_t a);
    int idx;
    idx = int'(a >> 2);
    if (idx < num_hw / 2)
        return {prog_hw[2*idx+1], prog_hw[2*idx]};
    return ~a;
endfunction

task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Stopping at first failure");
endtask

task automatic check_pc(input string name, input addr_t exp_val, input addr_t act_val);
    if (act_val !== exp_val)
    begin
        $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
        abort_run();
    end
endtask

task automatic check_word(input string name, input rv_instr_u exp_val,
                          input rv_instr_u act_val);
    if (act_val !== exp_val)
    begin
        $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
        abort_run();
    end
endtask

task automatic check_flag(input string name, input bit exp_val, input bit act_val);
    if (act_val !== exp_val)
    begin
        $display("Error %s: expected %b, actual %b", name, exp_val, act_val);
        abort_run();
    end
endtask

task automatic check_reg(input string name, input logic [4:0] exp_val,
                         input logic [4:0] act_val);
    if (act_val !== exp_val)
    begin
        $display("Error %s: expected x%0d, actual x%0d", name, exp_val, act_val);
        abort_run();
    end
endtask

task automatic check_imm(input string name, input logic [xlen-1:0] exp_val,
                         input logic [xlen-1:0] act_val);
    if (act_val !== exp_val)
    begin
        $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
        abort_run();
    end
endtask

// APB completer and output stalls, both off the one LCG
always @(posedge clk)
begin
    #2;
    if (psel && pwrite)
    begin
        $display("APB write transfer seen at address %h", paddr);
        abort_run();
    end
    pready = 1'b0;
    if (psel && !penable)
    begin
        rnd       = lcg_next();
        wait_left = rnd[31:30];     // 0 to 3 wait states
    end
    else if (psel && penable)
    begin
        if (wait_left == 2'd0)
        begin
            pready = 1'b1;
            prdata = fetch_word(paddr);
        end
        else
        begin
            wait_left = wait_left - 2'd1;
        end
    end
    rnd       = lcg_next();
    out_ready = rnd[31:30] != 2'b00;  // Stall about one cycle in four
end

always @(posedge clk)
begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_cycles)
    begin
        $display("Run timed out after %0d cycles without all instructions", cycle_count);
        abort_run();
    end
end

initial
begin
    arst_n    = 1'b0;
    pready    = 1'b0;
    prdata    = '0;
    out_ready = 1'b0;
    wait_left = 2'd0;
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;

    for (i = 0; i < num_instr; i = i + 1)
    begin
        @(negedge clk);
        while (!(out_valid && out_ready))
            @(negedge clk);
        got = {out_funct7, out_rs2, out_rs1, out_funct3, out_rd, out_opcode};
        check_pc($sformatf("instr %0d pc", i), exp_table[i].pc, out_pc);
        check_flag($sformatf("instr %0d compressed", i), exp_table[i].compressed,
                   out_compressed);
        check_flag($sformatf("instr %0d illegal", i), exp_table[i].illegal, out_illegal);
        check_word($sformatf("instr %0d word", i), exp_table[i].word, got);
        check_reg($sformatf("instr %0d rd", i), exp_table[i].rd, out_rd);
        check_reg($sformatf("instr %0d rs1", i), exp_table[i].rs1, out_rs1);
        check_reg($sformatf("instr %0d rs2", i), exp_table[i].rs2, out_rs2);
        check_imm($sformatf("instr %0d imm", i), exp_table[i].imm, out_imm);
    end

    $display("Result: PASSED");
    $finish;
end

endmodule

`default_nettype wire
